// ==== logic/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

	typedef logic [31:0] inst_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [31:0] word_t;

	localparam int PIPE_DEPTH = 3; // Cycles from in_valid to out_valid.

	// Major opcodes, instruction bits 6:0.
	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC = 7'b0010111;
	localparam logic [6:0] OPC_JAL = 7'b1101111;
	localparam logic [6:0] OPC_JALR = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD = 7'b0000011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;
	localparam logic [6:0] OPC_OPIMM = 7'b0010011;
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_FENCE = 7'b0001111;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	localparam logic [6:0] FUNCT7_ALT = 7'b0100000; // SUB, SRA and SRAI.
	localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

	typedef enum logic [5:0] {
		OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
		OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
		OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
		OP_SB, OP_SH, OP_SW,
		OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
		OP_SLLI, OP_SRLI, OP_SRAI,
		OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
		OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
		OP_FENCE, OP_ECALL, OP_EBREAK,
		OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
		OP_DIV, OP_DIVU, OP_REM, OP_REMU,
		OP_ILLEGAL
	} op_name_t;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_INC, ALU_SUB, ALU_SEQ, ALU_SNE,
		ALU_SLT, ALU_SGE, ALU_SLTU, ALU_SGEU,
		ALU_XOR, ALU_OR, ALU_AND,
		ALU_SLL, ALU_SRL, ALU_SRA
	} alu_op_t;

	typedef enum logic [3:0] {
		MEM_NONE, MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU,
		MEM_SB, MEM_SH, MEM_SW
	} mem_op_t;

	typedef enum logic [1:0] {
		UMULL, SMULH, SUMULH, UMULH
	} mul_op_t;

	typedef enum logic [1:0] {
		SDIV, UDIV, SREM, UREM
	} div_op_t;

	// Three bits wide so the code space matches the wider core write-back mux.
	typedef enum logic [2:0] {
		SEL_ALU, SEL_MEM, SEL_MUL, SEL_DIV
	} wb_src_t;

	typedef enum logic [2:0] {
		FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J,
		FMT_NONE
	} format_t;

	typedef struct packed {
		inst_t inst;
		op_name_t name;
	} match_payload_t;

	typedef struct packed {
		op_name_t name;
		word_t immediate;
		reg_addr_t rs1_addr;
		reg_addr_t rs2_addr;
		reg_addr_t rd_addr;
		logic rs1_rena;
		logic rs2_rena;
		logic rd_wena;
	} operand_payload_t;

endpackage

`default_nettype wire

// ==== logic/stage_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One pipeline hop. The payload only means something while valid is high.
interface stage_if #(
	parameter type payload_t = logic
);

	logic valid;
	payload_t payload;

	modport source (
		output valid,
		output payload
	);

	modport sink (
		input valid,
		input payload
	);

endinterface

`default_nettype wire

// ==== logic/match_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module match_stage (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input decode_pkg::inst_t inst,
	stage_if.source out
);

	decode_pkg::op_name_t match_name;

	// Bit layout is funct7, rs2, rs1, funct3, rd, opcode.
	always_comb begin
		casez (inst)
		{25'b?, decode_pkg::OPC_LUI}: match_name = decode_pkg::OP_LUI;
		{25'b?, decode_pkg::OPC_AUIPC}: match_name = decode_pkg::OP_AUIPC;
		{25'b?, decode_pkg::OPC_JAL}: match_name = decode_pkg::OP_JAL;
		{17'b?, 3'b000, 5'b?, decode_pkg::OPC_JALR}: match_name = decode_pkg::OP_JALR;
		{17'b?, 3'b000, 5'b?, decode_pkg::OPC_BRANCH}: match_name = decode_pkg::OP_BEQ;
		{17'b?, 3'b001, 5'b?, decode_pkg::OPC_BRANCH}: match_name = decode_pkg::OP_BNE;
		{17'b?, 3'b100, 5'b?, decode_pkg::OPC_BRANCH}: match_name = decode_pkg::OP_BLT;
		{17'b?, 3'b101, 5'b?, decode_pkg::OPC_BRANCH}: match_name = decode_pkg::OP_BGE;
		{17'b?, 3'b110, 5'b?, decode_pkg::OPC_BRANCH}: match_name = decode_pkg::OP_BLTU;
		{17'b?, 3'b111, 5'b?, decode_pkg::OPC_BRANCH}: match_name = decode_pkg::OP_BGEU;
		{17'b?, 3'b000, 5'b?, decode_pkg::OPC_LOAD}: match_name = decode_pkg::OP_LB;
		{17'b?, 3'b001, 5'b?, decode_pkg::OPC_LOAD}: match_name = decode_pkg::OP_LH;
		{17'b?, 3'b010, 5'b?, decode_pkg::OPC_LOAD}: match_name = decode_pkg::OP_LW;
		{17'b?, 3'b100, 5'b?, decode_pkg::OPC_LOAD}: match_name = decode_pkg::OP_LBU;
		{17'b?, 3'b101, 5'b?, decode_pkg::OPC_LOAD}: match_name = decode_pkg::OP_LHU;
		{17'b?, 3'b000, 5'b?, decode_pkg::OPC_STORE}: match_name = decode_pkg::OP_SB;
		{17'b?, 3'b001, 5'b?, decode_pkg::OPC_STORE}: match_name = decode_pkg::OP_SH;
		{17'b?, 3'b010, 5'b?, decode_pkg::OPC_STORE}: match_name = decode_pkg::OP_SW;
		{17'b?, 3'b000, 5'b?, decode_pkg::OPC_OPIMM}: match_name = decode_pkg::OP_ADDI;
		{17'b?, 3'b010, 5'b?, decode_pkg::OPC_OPIMM}: match_name = decode_pkg::OP_SLTI;
		{17'b?, 3'b011, 5'b?, decode_pkg::OPC_OPIMM}: match_name = decode_pkg::OP_SLTIU;
		{17'b?, 3'b100, 5'b?, decode_pkg::OPC_OPIMM}: match_name = decode_pkg::OP_XORI;
		{17'b?, 3'b110, 5'b?, decode_pkg::OPC_OPIMM}: match_name = decode_pkg::OP_ORI;
		{17'b?, 3'b111, 5'b?, decode_pkg::OPC_OPIMM}: match_name = decode_pkg::OP_ANDI;
		// Shift immediates keep funct7 in the upper immediate bits.
		{7'b0000000, 10'b?, 3'b001, 5'b?, decode_pkg::OPC_OPIMM}:
			match_name = decode_pkg::OP_SLLI;
		{7'b0000000, 10'b?, 3'b101, 5'b?, decode_pkg::OPC_OPIMM}:
			match_name = decode_pkg::OP_SRLI;
		{decode_pkg::FUNCT7_ALT, 10'b?, 3'b101, 5'b?, decode_pkg::OPC_OPIMM}:
			match_name = decode_pkg::OP_SRAI;
		{7'b0000000, 10'b?, 3'b000, 5'b?, decode_pkg::OPC_OP}: match_name = decode_pkg::OP_ADD;
		{decode_pkg::FUNCT7_ALT, 10'b?, 3'b000, 5'b?, decode_pkg::OPC_OP}:
			match_name = decode_pkg::OP_SUB;
		{7'b0000000, 10'b?, 3'b001, 5'b?, decode_pkg::OPC_OP}: match_name = decode_pkg::OP_SLL;
		{7'b0000000, 10'b?, 3'b010, 5'b?, decode_pkg::OPC_OP}: match_name = decode_pkg::OP_SLT;
		{7'b0000000, 10'b?, 3'b011, 5'b?, decode_pkg::OPC_OP}: match_name = decode_pkg::OP_SLTU;
		{7'b0000000, 10'b?, 3'b100, 5'b?, decode_pkg::OPC_OP}: match_name = decode_pkg::OP_XOR;
		{7'b0000000, 10'b?, 3'b101, 5'b?, decode_pkg::OPC_OP}: match_name = decode_pkg::OP_SRL;
		{decode_pkg::FUNCT7_ALT, 10'b?, 3'b101, 5'b?, decode_pkg::OPC_OP}:
			match_name = decode_pkg::OP_SRA;
		{7'b0000000, 10'b?, 3'b110, 5'b?, decode_pkg::OPC_OP}: match_name = decode_pkg::OP_OR;
		{7'b0000000, 10'b?, 3'b111, 5'b?, decode_pkg::OPC_OP}: match_name = decode_pkg::OP_AND;
		{17'b?, 3'b000, 5'b?, decode_pkg::OPC_FENCE}: match_name = decode_pkg::OP_FENCE;
		{25'b0, decode_pkg::OPC_SYSTEM}: match_name = decode_pkg::OP_ECALL;
		{11'b0, 1'b1, 13'b0, decode_pkg::OPC_SYSTEM}: match_name = decode_pkg::OP_EBREAK;
		{decode_pkg::FUNCT7_MULDIV, 10'b?, 3'b000, 5'b?, decode_pkg::OPC_OP}:
			match_name = decode_pkg::OP_MUL;
		{decode_pkg::FUNCT7_MULDIV, 10'b?, 3'b001, 5'b?, decode_pkg::OPC_OP}:
			match_name = decode_pkg::OP_MULH;
		{decode_pkg::FUNCT7_MULDIV, 10'b?, 3'b010, 5'b?, decode_pkg::OPC_OP}:
			match_name = decode_pkg::OP_MULHSU;
		{decode_pkg::FUNCT7_MULDIV, 10'b?, 3'b011, 5'b?, decode_pkg::OPC_OP}:
			match_name = decode_pkg::OP_MULHU;
		{decode_pkg::FUNCT7_MULDIV, 10'b?, 3'b100, 5'b?, decode_pkg::OPC_OP}:
			match_name = decode_pkg::OP_DIV;
		{decode_pkg::FUNCT7_MULDIV, 10'b?, 3'b101, 5'b?, decode_pkg::OPC_OP}:
			match_name = decode_pkg::OP_DIVU;
		{decode_pkg::FUNCT7_MULDIV, 10'b?, 3'b110, 5'b?, decode_pkg::OPC_OP}:
			match_name = decode_pkg::OP_REM;
		{decode_pkg::FUNCT7_MULDIV, 10'b?, 3'b111, 5'b?, decode_pkg::OPC_OP}:
			match_name = decode_pkg::OP_REMU;
		default: match_name = decode_pkg::OP_ILLEGAL;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			out.valid <= 1'b0;
		else
			out.valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			out.payload.inst <= inst;
			out.payload.name <= match_name;
		end
	end

	// The whole pipe keys off this strobe, so an X here would spread downstream.
	valid_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(out.valid));

endmodule

`default_nettype wire

// ==== logic/operand_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_stage (
	input logic clk,
	input logic reset,
	stage_if.sink in,
	stage_if.source out
);

	decode_pkg::inst_t word;
	decode_pkg::format_t fmt;
	decode_pkg::word_t imm;

	assign word = in.payload.inst;

	always_comb begin
		case (in.payload.name)
		decode_pkg::OP_LUI, decode_pkg::OP_AUIPC: fmt = decode_pkg::FMT_U;
		decode_pkg::OP_JAL: fmt = decode_pkg::FMT_J;
		decode_pkg::OP_JALR,
		decode_pkg::OP_LB, decode_pkg::OP_LH, decode_pkg::OP_LW,
		decode_pkg::OP_LBU, decode_pkg::OP_LHU,
		decode_pkg::OP_ADDI, decode_pkg::OP_SLTI, decode_pkg::OP_SLTIU,
		decode_pkg::OP_XORI, decode_pkg::OP_ORI, decode_pkg::OP_ANDI,
		decode_pkg::OP_SLLI, decode_pkg::OP_SRLI, decode_pkg::OP_SRAI: fmt = decode_pkg::FMT_I;
		decode_pkg::OP_BEQ, decode_pkg::OP_BNE, decode_pkg::OP_BLT,
		decode_pkg::OP_BGE, decode_pkg::OP_BLTU, decode_pkg::OP_BGEU: fmt = decode_pkg::FMT_B;
		decode_pkg::OP_SB, decode_pkg::OP_SH, decode_pkg::OP_SW: fmt = decode_pkg::FMT_S;
		decode_pkg::OP_ADD, decode_pkg::OP_SUB, decode_pkg::OP_SLL, decode_pkg::OP_SLT,
		decode_pkg::OP_SLTU, decode_pkg::OP_XOR, decode_pkg::OP_SRL, decode_pkg::OP_SRA,
		decode_pkg::OP_OR, decode_pkg::OP_AND,
		decode_pkg::OP_MUL, decode_pkg::OP_MULH, decode_pkg::OP_MULHSU, decode_pkg::OP_MULHU,
		decode_pkg::OP_DIV, decode_pkg::OP_DIVU, decode_pkg::OP_REM,
		decode_pkg::OP_REMU: fmt = decode_pkg::FMT_R;
		default: fmt = decode_pkg::FMT_NONE; // FENCE, ECALL, EBREAK and illegal words.
		endcase
	end

	always_comb begin
		case (fmt)
		decode_pkg::FMT_I: imm = {{21{word[31]}}, word[30:20]};
		decode_pkg::FMT_S: imm = {{21{word[31]}}, word[30:25], word[11:7]};
		decode_pkg::FMT_B: imm = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
		decode_pkg::FMT_U: imm = {word[31:12], 12'h000};
		decode_pkg::FMT_J: imm = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
		default: imm = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			out.valid <= 1'b0;
		else
			out.valid <= in.valid;
	end

	always_ff @(posedge clk) begin
		if (in.valid) begin
			out.payload.name <= in.payload.name;
			out.payload.immediate <= imm;
			out.payload.rs1_addr <= word[19:15]; // Addresses are taken even when unused.
			out.payload.rs2_addr <= word[24:20];
			out.payload.rd_addr <= word[11:7];
			out.payload.rs1_rena <= fmt inside {decode_pkg::FMT_R, decode_pkg::FMT_I,
				decode_pkg::FMT_S, decode_pkg::FMT_B};
			out.payload.rs2_rena <= fmt inside {decode_pkg::FMT_R, decode_pkg::FMT_S,
				decode_pkg::FMT_B};
			out.payload.rd_wena <= fmt inside {decode_pkg::FMT_R, decode_pkg::FMT_I,
				decode_pkg::FMT_U, decode_pkg::FMT_J};
		end
	end

endmodule

`default_nettype wire

// ==== logic/control_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_stage (
	input logic clk,
	input logic reset,
	stage_if.sink in,
	output logic out_valid,
	output decode_pkg::word_t immediate,
	output logic rs1_rena,
	output decode_pkg::reg_addr_t rs1_addr,
	output logic rs2_rena,
	output decode_pkg::reg_addr_t rs2_addr,
	output logic rd_wena,
	output decode_pkg::reg_addr_t rd_addr,
	output logic sel_pc,
	output logic sel_im,
	output decode_pkg::wb_src_t wb_src,
	output decode_pkg::alu_op_t alu_op,
	output decode_pkg::mem_op_t mem_op,
	output decode_pkg::mul_op_t mul_op,
	output decode_pkg::div_op_t div_op,
	output logic jump_ena,
	output logic jump_ind,
	output logic jump_alw,
	output logic illegal_inst
);

	decode_pkg::op_name_t name;
	decode_pkg::alu_op_t alu_next;
	decode_pkg::mem_op_t mem_next;
	decode_pkg::mul_op_t mul_next;
	decode_pkg::div_op_t div_next;
	decode_pkg::wb_src_t wb_next;

	assign name = in.payload.name;

	// Every field not listed for an instruction stays at its zero code.
	always_comb begin
		alu_next = decode_pkg::ALU_ADD;
		mem_next = decode_pkg::MEM_NONE;
		mul_next = decode_pkg::UMULL;
		div_next = decode_pkg::SDIV;
		wb_next = decode_pkg::SEL_ALU;
		case (name)
		decode_pkg::OP_JAL, decode_pkg::OP_JALR: alu_next = decode_pkg::ALU_INC; // Link is pc + 4.
		decode_pkg::OP_BEQ: alu_next = decode_pkg::ALU_SEQ;
		decode_pkg::OP_BNE: alu_next = decode_pkg::ALU_SNE;
		decode_pkg::OP_BLT, decode_pkg::OP_SLTI, decode_pkg::OP_SLT: alu_next = decode_pkg::ALU_SLT;
		decode_pkg::OP_BGE: alu_next = decode_pkg::ALU_SGE;
		decode_pkg::OP_BLTU, decode_pkg::OP_SLTIU,
		decode_pkg::OP_SLTU: alu_next = decode_pkg::ALU_SLTU;
		decode_pkg::OP_BGEU: alu_next = decode_pkg::ALU_SGEU;
		decode_pkg::OP_SUB: alu_next = decode_pkg::ALU_SUB;
		decode_pkg::OP_XORI, decode_pkg::OP_XOR: alu_next = decode_pkg::ALU_XOR;
		decode_pkg::OP_ORI, decode_pkg::OP_OR: alu_next = decode_pkg::ALU_OR;
		decode_pkg::OP_ANDI, decode_pkg::OP_AND: alu_next = decode_pkg::ALU_AND;
		decode_pkg::OP_SLLI, decode_pkg::OP_SLL: alu_next = decode_pkg::ALU_SLL;
		decode_pkg::OP_SRLI, decode_pkg::OP_SRL: alu_next = decode_pkg::ALU_SRL;
		decode_pkg::OP_SRAI, decode_pkg::OP_SRA: alu_next = decode_pkg::ALU_SRA;
		decode_pkg::OP_LB: mem_next = decode_pkg::MEM_LB;
		decode_pkg::OP_LH: mem_next = decode_pkg::MEM_LH;
		decode_pkg::OP_LW: mem_next = decode_pkg::MEM_LW;
		decode_pkg::OP_LBU: mem_next = decode_pkg::MEM_LBU;
		decode_pkg::OP_LHU: mem_next = decode_pkg::MEM_LHU;
		decode_pkg::OP_SB: mem_next = decode_pkg::MEM_SB;
		decode_pkg::OP_SH: mem_next = decode_pkg::MEM_SH;
		decode_pkg::OP_SW: mem_next = decode_pkg::MEM_SW;
		decode_pkg::OP_MULH: mul_next = decode_pkg::SMULH;
		decode_pkg::OP_MULHSU: mul_next = decode_pkg::SUMULH;
		decode_pkg::OP_MULHU: mul_next = decode_pkg::UMULH;
		decode_pkg::OP_DIVU: div_next = decode_pkg::UDIV;
		decode_pkg::OP_REM: div_next = decode_pkg::SREM;
		decode_pkg::OP_REMU: div_next = decode_pkg::UREM;
		default: ;
		endcase
		if (mem_next != decode_pkg::MEM_NONE)
			wb_next = decode_pkg::SEL_MEM; // Stores select it too, as the core expects.
		else if (name inside {decode_pkg::OP_MUL, decode_pkg::OP_MULH, decode_pkg::OP_MULHSU,
				decode_pkg::OP_MULHU})
			wb_next = decode_pkg::SEL_MUL;
		else if (name inside {decode_pkg::OP_DIV, decode_pkg::OP_DIVU, decode_pkg::OP_REM,
				decode_pkg::OP_REMU})
			wb_next = decode_pkg::SEL_DIV;
	end

	always_ff @(posedge clk) begin
		if (reset)
			out_valid <= 1'b0;
		else
			out_valid <= in.valid;
	end

	always_ff @(posedge clk) begin
		if (in.valid) begin
			immediate <= in.payload.immediate;
			rs1_rena <= in.payload.rs1_rena;
			rs1_addr <= in.payload.rs1_addr;
			rs2_rena <= in.payload.rs2_rena;
			rs2_addr <= in.payload.rs2_addr;
			rd_wena <= in.payload.rd_wena;
			rd_addr <= in.payload.rd_addr;
			sel_pc <= name inside {decode_pkg::OP_AUIPC, decode_pkg::OP_JAL, decode_pkg::OP_JALR};
			sel_im <= name inside {decode_pkg::OP_LUI, decode_pkg::OP_AUIPC,
				[decode_pkg::OP_LB:decode_pkg::OP_SW], [decode_pkg::OP_ADDI:decode_pkg::OP_SRAI]};
			wb_src <= wb_next;
			alu_op <= alu_next;
			mem_op <= mem_next;
			mul_op <= mul_next;
			div_op <= div_next;
			jump_ena <= name inside {decode_pkg::OP_JAL, decode_pkg::OP_JALR,
				[decode_pkg::OP_BEQ:decode_pkg::OP_BGEU]};
			jump_ind <= name == decode_pkg::OP_JALR;
			jump_alw <= name inside {decode_pkg::OP_JAL, decode_pkg::OP_JALR};
			illegal_inst <= name == decode_pkg::OP_ILLEGAL;
		end
	end

	// The branch unit only looks at jump_alw once jump_ena is set.
	alw_needs_ena: assert property (@(posedge clk) disable iff (reset)
		out_valid && jump_alw |-> jump_ena);

	// Memory accesses always form their address from rs1 plus the immediate.
	mem_needs_im: assert property (@(posedge clk) disable iff (reset)
		out_valid && mem_op != decode_pkg::MEM_NONE |-> sel_im);

endmodule

`default_nettype wire

// ==== logic/decode_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_pipe (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input decode_pkg::inst_t inst,
	output logic out_valid,
	output decode_pkg::word_t immediate,
	output logic rs1_rena,
	output decode_pkg::reg_addr_t rs1_addr,
	output logic rs2_rena,
	output decode_pkg::reg_addr_t rs2_addr,
	output logic rd_wena,
	output decode_pkg::reg_addr_t rd_addr,
	output logic sel_pc,
	output logic sel_im,
	output decode_pkg::wb_src_t wb_src,
	output decode_pkg::alu_op_t alu_op,
	output decode_pkg::mem_op_t mem_op,
	output decode_pkg::mul_op_t mul_op,
	output decode_pkg::div_op_t div_op,
	output logic jump_ena,
	output logic jump_ind,
	output logic jump_alw,
	output logic illegal_inst
);

	stage_if #(.payload_t(decode_pkg::match_payload_t)) match_to_operand ();
	stage_if #(.payload_t(decode_pkg::operand_payload_t)) operand_to_control ();

	match_stage match0 (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.inst(inst),
		.out(match_to_operand.source)
	);

	operand_stage operand0 (
		.clk(clk),
		.reset(reset),
		.in(match_to_operand.sink),
		.out(operand_to_control.source)
	);

	control_stage control0 (
		.clk(clk),
		.reset(reset),
		.in(operand_to_control.sink),
		.out_valid(out_valid),
		.immediate(immediate),
		.rs1_rena(rs1_rena),
		.rs1_addr(rs1_addr),
		.rs2_rena(rs2_rena),
		.rs2_addr(rs2_addr),
		.rd_wena(rd_wena),
		.rd_addr(rd_addr),
		.sel_pc(sel_pc),
		.sel_im(sel_im),
		.wb_src(wb_src),
		.alu_op(alu_op),
		.mem_op(mem_op),
		.mul_op(mul_op),
		.div_op(div_op),
		.jump_ena(jump_ena),
		.jump_ind(jump_ind),
		.jump_alw(jump_alw),
		.illegal_inst(illegal_inst)
	);

endmodule

`default_nettype wire

// ==== testbench/decode_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_checker (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input decode_pkg::inst_t inst,
	input logic out_valid,
	input decode_pkg::word_t immediate,
	input logic rs1_rena,
	input decode_pkg::reg_addr_t rs1_addr,
	input logic rs2_rena,
	input decode_pkg::reg_addr_t rs2_addr,
	input logic rd_wena,
	input decode_pkg::reg_addr_t rd_addr,
	input logic sel_pc,
	input logic sel_im,
	input logic [2:0] wb_src,
	input logic [3:0] alu_op,
	input logic [3:0] mem_op,
	input logic [1:0] mul_op,
	input logic [1:0] div_op,
	input logic jump_ena,
	input logic jump_ind,
	input logic jump_alw,
	input logic illegal_inst,
	output int errors,
	output int checks,
	output int pending
);

	typedef struct packed {
		logic [31:0] immediate;
		logic rs1_rena;
		logic [4:0] rs1_addr;
		logic rs2_rena;
		logic [4:0] rs2_addr;
		logic rd_wena;
		logic [4:0] rd_addr;
		logic sel_pc;
		logic sel_im;
		logic [2:0] wb_src;
		logic [3:0] alu_op;
		logic [3:0] mem_op;
		logic [1:0] mul_op;
		logic [1:0] div_op;
		logic jump_ena;
		logic jump_ind;
		logic jump_alw;
		logic illegal_inst;
	} result_t;

	result_t expect_q[$];
	int stamp_q[$]; // Cycle in which each queued word was sampled.
	result_t want;
	int stamp;
	int cycle = 0;
	int error_count = 0;
	int check_count = 0;
	int pending_count = 0;

	assign errors = error_count;
	assign checks = check_count;
	assign pending = pending_count;

	// The reference decode follows the RV32I and RV32M opcode map.
	function automatic result_t model(input decode_pkg::inst_t w);
		result_t r;
		logic [6:0] opc;
		logic [6:0] f7;
		logic [2:0] f3;
		logic legal;
		r = '0;
		opc = w[6:0];
		f3 = w[14:12];
		f7 = w[31:25];
		legal = 1'b1;
		case (opc)
		decode_pkg::OPC_LUI, decode_pkg::OPC_AUIPC: begin
			r.immediate = {w[31:12], 12'b0};
			r.sel_im = 1'b1;
			r.sel_pc = opc == decode_pkg::OPC_AUIPC;
			r.rd_wena = 1'b1;
		end
		decode_pkg::OPC_JAL, decode_pkg::OPC_JALR: begin
			if (opc == decode_pkg::OPC_JAL)
				r.immediate = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			else
				r.immediate = {{20{w[31]}}, w[31:20]};
			legal = opc == decode_pkg::OPC_JAL || f3 == 3'b000;
			r.rs1_rena = opc == decode_pkg::OPC_JALR;
			r.jump_ind = opc == decode_pkg::OPC_JALR;
			r.rd_wena = 1'b1;
			r.sel_pc = 1'b1;
			r.alu_op = decode_pkg::ALU_INC;
			r.jump_ena = 1'b1;
			r.jump_alw = 1'b1;
		end
		decode_pkg::OPC_BRANCH: begin
			r.immediate = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			r.rs1_rena = 1'b1;
			r.rs2_rena = 1'b1;
			r.jump_ena = 1'b1;
			case (f3)
			3'b000: r.alu_op = decode_pkg::ALU_SEQ;
			3'b001: r.alu_op = decode_pkg::ALU_SNE;
			3'b100: r.alu_op = decode_pkg::ALU_SLT;
			3'b101: r.alu_op = decode_pkg::ALU_SGE;
			3'b110: r.alu_op = decode_pkg::ALU_SLTU;
			3'b111: r.alu_op = decode_pkg::ALU_SGEU;
			default: legal = 1'b0;
			endcase
		end
		decode_pkg::OPC_LOAD: begin
			r.immediate = {{20{w[31]}}, w[31:20]};
			r.rs1_rena = 1'b1;
			r.rd_wena = 1'b1;
			r.sel_im = 1'b1;
			r.wb_src = decode_pkg::SEL_MEM;
			case (f3)
			3'b000: r.mem_op = decode_pkg::MEM_LB;
			3'b001: r.mem_op = decode_pkg::MEM_LH;
			3'b010: r.mem_op = decode_pkg::MEM_LW;
			3'b100: r.mem_op = decode_pkg::MEM_LBU;
			3'b101: r.mem_op = decode_pkg::MEM_LHU;
			default: legal = 1'b0;
			endcase
		end
		decode_pkg::OPC_STORE: begin
			r.immediate = {{20{w[31]}}, w[31:25], w[11:7]};
			r.rs1_rena = 1'b1;
			r.rs2_rena = 1'b1;
			r.sel_im = 1'b1;
			r.wb_src = decode_pkg::SEL_MEM; // The write-back mux sees memory even for stores.
			case (f3)
			3'b000: r.mem_op = decode_pkg::MEM_SB;
			3'b001: r.mem_op = decode_pkg::MEM_SH;
			3'b010: r.mem_op = decode_pkg::MEM_SW;
			default: legal = 1'b0;
			endcase
		end
		decode_pkg::OPC_OPIMM: begin
			r.immediate = {{20{w[31]}}, w[31:20]};
			r.rs1_rena = 1'b1;
			r.rd_wena = 1'b1;
			r.sel_im = 1'b1;
			case (f3)
			3'b000: r.alu_op = decode_pkg::ALU_ADD;
			3'b010: r.alu_op = decode_pkg::ALU_SLT;
			3'b011: r.alu_op = decode_pkg::ALU_SLTU;
			3'b100: r.alu_op = decode_pkg::ALU_XOR;
			3'b110: r.alu_op = decode_pkg::ALU_OR;
			3'b111: r.alu_op = decode_pkg::ALU_AND;
			3'b001: begin
				r.alu_op = decode_pkg::ALU_SLL;
				legal = f7 == 7'b0000000;
			end
			default: begin
				r.alu_op = f7[5] ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
				legal = f7 == 7'b0000000 || f7 == decode_pkg::FUNCT7_ALT;
			end
			endcase
		end
		decode_pkg::OPC_OP: begin
			r.rs1_rena = 1'b1;
			r.rs2_rena = 1'b1;
			r.rd_wena = 1'b1;
			if (f7 == decode_pkg::FUNCT7_MULDIV) begin
				r.wb_src = f3[2] ? decode_pkg::SEL_DIV : decode_pkg::SEL_MUL;
				case (f3)
				3'b001: r.mul_op = decode_pkg::SMULH;
				3'b010: r.mul_op = decode_pkg::SUMULH;
				3'b011: r.mul_op = decode_pkg::UMULH;
				3'b101: r.div_op = decode_pkg::UDIV;
				3'b110: r.div_op = decode_pkg::SREM;
				3'b111: r.div_op = decode_pkg::UREM;
				default: ; // MUL and DIV use the zero codes.
				endcase
			end else if (f7 == 7'b0000000) begin
				case (f3)
				3'b000: r.alu_op = decode_pkg::ALU_ADD;
				3'b001: r.alu_op = decode_pkg::ALU_SLL;
				3'b010: r.alu_op = decode_pkg::ALU_SLT;
				3'b011: r.alu_op = decode_pkg::ALU_SLTU;
				3'b100: r.alu_op = decode_pkg::ALU_XOR;
				3'b101: r.alu_op = decode_pkg::ALU_SRL;
				3'b110: r.alu_op = decode_pkg::ALU_OR;
				default: r.alu_op = decode_pkg::ALU_AND;
				endcase
			end else if (f7 == decode_pkg::FUNCT7_ALT && f3 == 3'b000)
				r.alu_op = decode_pkg::ALU_SUB;
			else if (f7 == decode_pkg::FUNCT7_ALT && f3 == 3'b101)
				r.alu_op = decode_pkg::ALU_SRA;
			else
				legal = 1'b0;
		end
		decode_pkg::OPC_FENCE: legal = f3 == 3'b000;
		decode_pkg::OPC_SYSTEM: legal = w == 32'h0000_0073 || w == 32'h0010_0073;
		default: legal = 1'b0;
		endcase
		if (!legal) begin
			r = '0;
			r.illegal_inst = 1'b1;
		end
		r.rs1_addr = w[19:15];
		r.rs2_addr = w[24:20];
		r.rd_addr = w[11:7];
		return r;
	endfunction

	task automatic compare_field(input string name, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		if (exp_val !== act_val) begin
			$display("Error at time %0t: %s expected %0h, got %0h", $time, name, exp_val,
				act_val);
			error_count = error_count + 1;
		end
	endtask

	always @(posedge clk) begin
		cycle = cycle + 1;
		if (reset) begin
			if (cycle > 1 && out_valid !== 1'b0) begin
				$display("out_valid was not low during reset at time %0t", $time);
				error_count = error_count + 1;
			end
		end else begin
			if (out_valid) begin
				if (expect_q.size() == 0) begin
					$display("out_valid at time %0t with no instruction in flight", $time);
					error_count = error_count + 1;
				end else begin
					want = expect_q.pop_front();
					stamp = stamp_q.pop_front();
					if (cycle != stamp + decode_pkg::PIPE_DEPTH) begin
						$display("Word came out %0d cycles after entry at time %0t",
							cycle - stamp, $time);
						error_count = error_count + 1;
					end
					compare_field("immediate", want.immediate, immediate);
					compare_field("rs1_rena", 32'(want.rs1_rena), 32'(rs1_rena));
					compare_field("rs1_addr", 32'(want.rs1_addr), 32'(rs1_addr));
					compare_field("rs2_rena", 32'(want.rs2_rena), 32'(rs2_rena));
					compare_field("rs2_addr", 32'(want.rs2_addr), 32'(rs2_addr));
					compare_field("rd_wena", 32'(want.rd_wena), 32'(rd_wena));
					compare_field("rd_addr", 32'(want.rd_addr), 32'(rd_addr));
					compare_field("sel_pc", 32'(want.sel_pc), 32'(sel_pc));
					compare_field("sel_im", 32'(want.sel_im), 32'(sel_im));
					compare_field("wb_src", 32'(want.wb_src), 32'(wb_src));
					compare_field("alu_op", 32'(want.alu_op), 32'(alu_op));
					compare_field("mem_op", 32'(want.mem_op), 32'(mem_op));
					compare_field("mul_op", 32'(want.mul_op), 32'(mul_op));
					compare_field("div_op", 32'(want.div_op), 32'(div_op));
					compare_field("jump_ena", 32'(want.jump_ena), 32'(jump_ena));
					compare_field("jump_ind", 32'(want.jump_ind), 32'(jump_ind));
					compare_field("jump_alw", 32'(want.jump_alw), 32'(jump_alw));
					compare_field("illegal_inst", 32'(want.illegal_inst), 32'(illegal_inst));
					check_count = check_count + 1;
				end
			end else if (stamp_q.size() != 0 &&
					cycle >= stamp_q[0] + decode_pkg::PIPE_DEPTH) begin
				$display("No out_valid %0d cycles after a word entered, at time %0t",
					decode_pkg::PIPE_DEPTH, $time);
				error_count = error_count + 1;
				void'(expect_q.pop_front());
				void'(stamp_q.pop_front());
			end
			if (in_valid) begin
				expect_q.push_back(model(inst));
				stamp_q.push_back(cycle);
			end
		end
		pending_count = expect_q.size();
	end

endmodule

`default_nettype wire

// ==== testbench/decode_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_tb;

	localparam int NUM_TESTS = 6;
	localparam int WORDS_PER_TEST = 200;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * WORDS_PER_TEST * 2 + 100;

	logic clk;
	logic reset;
	logic in_valid;
	decode_pkg::inst_t inst;
	logic out_valid;
	decode_pkg::word_t immediate;
	logic rs1_rena;
	decode_pkg::reg_addr_t rs1_addr;
	logic rs2_rena;
	decode_pkg::reg_addr_t rs2_addr;
	logic rd_wena;
	decode_pkg::reg_addr_t rd_addr;
	logic sel_pc;
	logic sel_im;
	decode_pkg::wb_src_t wb_src;
	decode_pkg::alu_op_t alu_op;
	decode_pkg::mem_op_t mem_op;
	decode_pkg::mul_op_t mul_op;
	decode_pkg::div_op_t div_op;
	logic jump_ena;
	logic jump_ind;
	logic jump_alw;
	logic illegal_inst;
	int errors;
	int checks;
	int pending;
	int cycle_count;
	integer seed;

	logic [2:0] branch_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
	logic [2:0] load_f3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};

	decode_pipe dut0 (.*);

	decode_checker checker0 (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Random fields first, then the group's fixed opcode bits on top.
	task automatic make_word(input int group, output decode_pkg::inst_t w);
		logic [31:0] r;
		int g;
		w = $random(seed);
		r = $random(seed);
		g = (group == 5) ? int'(r[31:28] % 5) : group;
		if (r[2:0] != 3'b000) begin // One word in eight stays fully random.
			case (g)
			0: case (r[4:3])
				2'd0: w[6:0] = decode_pkg::OPC_LUI;
				2'd1: w[6:0] = decode_pkg::OPC_AUIPC;
				2'd2: begin
					w[6:0] = decode_pkg::OPC_OPIMM;
					if (w[14:12] == 3'b001)
						w[31:25] = 7'b0000000;
					else if (w[14:12] == 3'b101)
						w[31:25] = r[5] ? decode_pkg::FUNCT7_ALT : 7'b0000000;
				end
				default: begin
					w[6:0] = decode_pkg::OPC_OP;
					w[31:25] = (r[5] && w[14:12] inside {3'b000, 3'b101}) ?
						decode_pkg::FUNCT7_ALT : 7'b0000000;
				end
				endcase
			1: case (r[4:3])
				2'd2: w[6:0] = decode_pkg::OPC_JAL;
				2'd3: begin
					w[6:0] = decode_pkg::OPC_JALR;
					w[14:12] = 3'b000;
				end
				default: begin
					w[6:0] = decode_pkg::OPC_BRANCH;
					w[14:12] = branch_f3[3'(r[10:8] % 6)];
				end
				endcase
			2: if (r[3]) begin
					w[6:0] = decode_pkg::OPC_LOAD;
					w[14:12] = load_f3[3'(r[10:8] % 5)];
				end else begin
					w[6:0] = decode_pkg::OPC_STORE;
					w[14:12] = 3'(r[10:8] % 3);
				end
			3: begin
				w[6:0] = decode_pkg::OPC_OP;
				w[31:25] = decode_pkg::FUNCT7_MULDIV;
			end
			default: case (r[4:3])
				2'd0: begin
					w[6:0] = decode_pkg::OPC_FENCE;
					w[14:12] = 3'b000;
				end
				2'd1: w = 32'h0000_0073; // ECALL
				2'd2: w = 32'h0010_0073; // EBREAK
				default: ;
				endcase
			endcase
		end
	endtask

	task automatic run_test(input int group, input string label);
		int sent;
		int errors_before;
		int checks_before;
		logic [31:0] r;
		decode_pkg::inst_t w;
		sent = 0;
		errors_before = errors;
		checks_before = checks;
		while (sent < WORDS_PER_TEST) begin
			@(posedge clk);
			r = $random(seed);
			if (group == 5 || r[1:0] != 2'b00) begin // The burst test never idles.
				make_word(group, w);
				in_valid <= 1'b1;
				inst <= w;
				sent = sent + 1;
			end else begin
				in_valid <= 1'b0;
				inst <= r;
			end
		end
		@(posedge clk);
		in_valid <= 1'b0;
		@(negedge clk);
		while (pending != 0)
			@(negedge clk);
		$display("%s: %0d words, %0d checked, %0d errors", label, sent,
			checks - checks_before, errors - errors_before);
	endtask

	initial begin : watchdog
		cycle_count = 0;
		while (cycle_count <= TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count = cycle_count + 1;
		end
		$display("Timeout: the run went past %0d cycles", TIMEOUT_CYCLES);
		$display("Test failed");
		$finish;
	end

	initial begin
		seed = 32'he1fc9bd7;
		reset = 1'b1;
		in_valid = 1'b0;
		inst = '0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		run_test(0, "alu and immediates");
		run_test(1, "branches and jumps");
		run_test(2, "loads and stores");
		run_test(3, "multiply and divide");
		run_test(4, "illegal and system words");
		run_test(5, "back-to-back burst");
		$display("%0d instructions checked, %0d errors", checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
logic/decode_pkg.sv
logic/stage_if.sv
logic/match_stage.sv
logic/operand_stage.sv
logic/control_stage.sv
logic/decode_pipe.sv
testbench/decode_checker.sv
testbench/decode_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the decoder testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module decode_tb -o decode_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/decode_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" "$LOG"; then
	exit 1
fi
exit 0
